//--- hw/potionPkg.sv
package potionPkg;

    ////////////////////////////////////////
    // Board geometry
    ////////////////////////////////////////
    localparam int NUM_TUBES    = 7;
    localparam int TUBE_DEPTH   = 4;
    localparam int CURSOR_SLOTS = 8;  // Two rows of four
    localparam int QUIT_SLOT    = 7;  // Slot without a tube

    typedef enum logic [2:0] {
        EMPTY = 3'd0,
        COL1  = 3'd1,
        COL2  = 3'd2,
        COL3  = 3'd3,
        COL4  = 3'd4,
        COL5  = 3'd5,
        COL6  = 3'd6
    } colourT;

    typedef colourT [TUBE_DEPTH-1:0] tubeT;   // Index 0 is the bottom slot
    typedef tubeT   [NUM_TUBES-1:0]  boardT;

    typedef logic [2:0] levelT;  // Units in one tube
    typedef logic [2:0] slotT;   // Cursor or tube index

    // Codes shared with the outer game FSM
    typedef enum logic [3:0] {
        MENU  = 4'd0,
        PLAY  = 4'd5,
        SETUP = 4'd6
    } phaseT;

    typedef struct packed {
        logic left;
        logic right;
        logic up;
        logic down;
        logic centre;
    } btnT;

    typedef struct packed {
        logic valid;
        slotT src;
        slotT dst;
    } pourReqT;

    // Start layout, tubes 0 and 1 mixed, tube 6 spare
    localparam boardT START_BOARD = '{
        0: '{0: COL1, 1: COL2, 2: COL1, 3: COL2},
        1: '{0: COL2, 1: COL1, 2: COL2, 3: COL1},
        2: '{default: COL3},
        3: '{default: COL4},
        4: '{default: COL5},
        5: '{default: COL6},
        6: '{default: EMPTY}
    };

endpackage

//--- hw/tubeBoard.sv
`timescale 1ns/100ps

module tubeBoard #(
    parameter int SETTLE_CYCLES = 5000
) (
    input  logic                single_pulse_clk,
    input  logic                rstN,
    input  potionPkg::phaseT    phase,
    input  potionPkg::pourReqT  pourReq,
    output potionPkg::boardT    board,
    output logic                setupDone,
    output logic                pourBusy,
    output logic                solved
);

    localparam int CNT_W = $clog2(SETTLE_CYCLES + 2);

    potionPkg::levelT  levels [potionPkg::NUM_TUBES];  // Fill count per tube
    logic [CNT_W-1:0]  settleCnt;
    logic              layoutLoaded;
    potionPkg::slotT   srcQ;
    potionPkg::slotT   dstQ;
    logic              checkPending;  // Win check due on next edge

    potionPkg::levelT  srcLvl;
    potionPkg::levelT  dstLvl;
    potionPkg::colourT srcTop;
    potionPkg::colourT srcBelow;
    potionPkg::colourT dstTop;
    logic              moveOk;
    logic              moreAfter;
    logic              allSolved;

    function automatic potionPkg::levelT fillLevel(input potionPkg::tubeT tube);
        potionPkg::levelT n;
        n = '0;
        for (int s = 0; s < potionPkg::TUBE_DEPTH; s++) begin
            if (tube[s] != potionPkg::EMPTY) n = n + 1'b1;
        end
        return n;
    endfunction

    ////////////////////////////////////////
    // Pour rule
    ////////////////////////////////////////
    always_comb begin
        srcLvl   = '0;
        dstLvl   = '0;
        srcTop   = potionPkg::EMPTY;
        srcBelow = potionPkg::EMPTY;
        dstTop   = potionPkg::EMPTY;
        if (srcQ < potionPkg::NUM_TUBES) begin
            srcLvl = levels[srcQ];
            if (srcLvl != 0) srcTop = board[srcQ][srcLvl - 1'b1];
            if (srcLvl > 1) srcBelow = board[srcQ][srcLvl - 2'd2];
        end
        if (dstQ < potionPkg::NUM_TUBES) begin  // Slot 7 is never a legal target
            dstLvl = levels[dstQ];
            if (dstLvl != 0) dstTop = board[dstQ][dstLvl - 1'b1];
        end
        moveOk = (srcQ < potionPkg::NUM_TUBES) && (dstQ < potionPkg::NUM_TUBES)
                 && (srcQ != dstQ) && (srcLvl != 0) && (dstLvl < potionPkg::TUBE_DEPTH)
                 && ((dstLvl == 0) || (dstTop == srcTop));
        // After this move the destination top equals srcTop
        moreAfter = moveOk && (srcLvl > 1) && (dstLvl < potionPkg::TUBE_DEPTH - 1)
                    && (srcBelow == srcTop);
    end

    // Every tube uniform, empty tubes included
    always_comb begin
        allSolved = 1'b1;
        for (int t = 0; t < potionPkg::NUM_TUBES; t++) begin
            for (int s = 1; s < potionPkg::TUBE_DEPTH; s++) begin
                if (board[t][s] != board[t][0]) allSolved = 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Setup, pour engine, win check
    ////////////////////////////////////////
    always_ff @(posedge single_pulse_clk) begin
        if (!rstN) begin
            board        <= '{default: potionPkg::EMPTY};
            for (int t = 0; t < potionPkg::NUM_TUBES; t++) begin
                levels[t] <= '0;
            end
            settleCnt    <= '0;
            layoutLoaded <= 1'b0;
            setupDone    <= 1'b0;
            pourBusy     <= 1'b0;
            checkPending <= 1'b0;
            solved       <= 1'b0;
            srcQ         <= '0;
            dstQ         <= '0;
        end else begin
            solved <= 1'b0;
            if (phase == potionPkg::SETUP) begin
                if (!layoutLoaded) begin
                    // First setup edge loads the fixed layout
                    board <= potionPkg::START_BOARD;
                    for (int t = 0; t < potionPkg::NUM_TUBES; t++) begin
                        levels[t] <= fillLevel(potionPkg::START_BOARD[t]);
                    end
                    layoutLoaded <= 1'b1;
                    settleCnt    <= '0;
                    pourBusy     <= 1'b0;
                    checkPending <= 1'b0;
                end else if (!setupDone) begin
                    if (settleCnt == CNT_W'(SETTLE_CYCLES)) setupDone <= 1'b1;
                    else settleCnt <= settleCnt + 1'b1;
                end
            end else begin
                setupDone    <= 1'b0;
                layoutLoaded <= 1'b0;
                settleCnt    <= '0;

                if (checkPending) begin
                    solved       <= allSolved;
                    checkPending <= 1'b0;
                end

                if (pourBusy) begin
                    if (moveOk) begin  // One unit per edge
                        board[dstQ][dstLvl[1:0]]    <= srcTop;
                        board[srcQ][srcLvl - 1'b1] <= potionPkg::EMPTY;
                        levels[srcQ] <= srcLvl - 1'b1;
                        levels[dstQ] <= dstLvl + 1'b1;
                    end
                    pourBusy     <= moreAfter;
                    checkPending <= !moreAfter;
                end else if (pourReq.valid) begin
                    srcQ     <= pourReq.src;
                    dstQ     <= pourReq.dst;
                    pourBusy <= 1'b1;
                end
            end
        end
    end

endmodule

//--- hw/playControl.sv
`timescale 1ns/100ps

module playControl (
    input  logic                                single_pulse_clk,
    input  logic                                rstN,
    input  potionPkg::phaseT                    phase,
    input  potionPkg::btnT                      buttons,
    input  logic                                pourBusy,
    input  logic                                solved,
    input  logic                                timeUp,
    output potionPkg::pourReqT                  pourReq,
    output logic                                gameEnded,
    output logic [potionPkg::CURSOR_SLOTS-1:0]  selectedMask,
    output logic [potionPkg::CURSOR_SLOTS-1:0]  confirmedMask
);

    localparam int ROW_LEN = potionPkg::CURSOR_SLOTS / 2;

    potionPkg::slotT cursor;
    potionPkg::slotT confSlot;
    logic            confValid;  // A source tube is held

    always_ff @(posedge single_pulse_clk) begin
        if (!rstN) begin
            cursor    <= '0;
            confSlot  <= '0;
            confValid <= 1'b0;
            pourReq   <= '0;
            gameEnded <= 1'b0;
        end else begin
            pourReq.valid <= 1'b0;  // Single cycle request
            if (phase == potionPkg::MENU) begin
                cursor    <= '0;
                confValid <= 1'b0;
                gameEnded <= 1'b0;
            end else begin
                if (solved || timeUp) gameEnded <= 1'b1;

                // Buttons are dropped while a pour runs
                if (phase == potionPkg::PLAY && !pourBusy) begin
                    ////////////////////////////////////////
                    // Cursor movement
                    ////////////////////////////////////////
                    if (buttons.left) begin
                        if (cursor % ROW_LEN != 0) cursor <= cursor - 1'b1;
                    end else if (buttons.right) begin
                        if (cursor % ROW_LEN != ROW_LEN - 1) cursor <= cursor + 1'b1;
                    end else if (buttons.up) begin
                        if (cursor >= ROW_LEN) cursor <= cursor - potionPkg::slotT'(ROW_LEN);
                    end else if (buttons.down) begin
                        if (cursor < ROW_LEN) cursor <= cursor + potionPkg::slotT'(ROW_LEN);
                    end

                    ////////////////////////////////////////
                    // Confirm, quit and pour
                    ////////////////////////////////////////
                    if (buttons.centre) begin
                        if (confValid && cursor == confSlot) begin
                            confValid <= 1'b0;
                        end else if (!confValid && cursor == potionPkg::QUIT_SLOT) begin
                            gameEnded <= 1'b1;  // Give up
                        end else if (!confValid) begin
                            confSlot  <= cursor;
                            confValid <= 1'b1;
                        end else begin
                            pourReq.valid <= 1'b1;
                            pourReq.src   <= confSlot;
                            pourReq.dst   <= cursor;
                            confValid     <= 1'b0;
                        end
                    end
                end
            end
        end
    end

    assign selectedMask  = {{(potionPkg::CURSOR_SLOTS-1){1'b0}}, 1'b1} << cursor;
    assign confirmedMask = confValid ? ({{(potionPkg::CURSOR_SLOTS-1){1'b0}}, 1'b1} << confSlot)
                                     : '0;

endmodule

//--- hw/gameTimer.sv
`timescale 1ns/100ps

module gameTimer #(
    parameter logic [24:0] TIME_LIMIT = 25'd60000
) (
    input  logic             single_pulse_clk,
    input  logic             rstN,
    input  potionPkg::phaseT phase,
    output logic             timeUp,
    output logic [6:0]       timePercent
);

    localparam logic [31:0] PERCENT_SCALE = 32'd100;

    logic [24:0] timeLeft;
    logic [31:0] scaled;

    ////////////////////////////////////////
    // Countdown
    ////////////////////////////////////////
    always_ff @(posedge single_pulse_clk) begin
        if (!rstN) begin
            timeLeft <= TIME_LIMIT;
            timeUp   <= 1'b0;
        end else begin
            timeUp <= 1'b0;
            if (phase == potionPkg::PLAY) begin
                if (timeLeft == 25'd1) begin
                    timeLeft <= TIME_LIMIT;  // Expired so rearm
                    timeUp   <= 1'b1;
                end else begin
                    timeLeft <= timeLeft - 1'b1;
                end
            end else if (phase == potionPkg::MENU) begin
                timeLeft <= TIME_LIMIT;
            end
        end
    end

    // Remaining time as a whole percentage
    assign scaled      = 32'(timeLeft) * PERCENT_SCALE;
    assign timePercent = 7'(scaled / 32'(TIME_LIMIT));

endmodule

//--- hw/potionGame.sv
`timescale 1ns/100ps

module potionGame #(
    parameter logic [24:0] TIME_LIMIT    = 25'd60000,
    parameter int          SETTLE_CYCLES = 5000
) (
    input  logic                                single_pulse_clk,
    input  logic                                rstN,
    input  potionPkg::phaseT                    phase,
    input  potionPkg::btnT                      buttons,
    output potionPkg::boardT                    board,
    output logic                                setupDone,
    output logic                                gameEnded,
    output logic [potionPkg::CURSOR_SLOTS-1:0]  selectedMask,
    output logic [potionPkg::CURSOR_SLOTS-1:0]  confirmedMask,
    output logic [6:0]                          timePercent
);

    potionPkg::pourReqT pourReq;
    logic               pourBusy;  // Back-pressure into the controls
    logic               solved;
    logic               timeUp;

    ////////////////////////////////////////
    // Tube storage and pour engine
    ////////////////////////////////////////
    tubeBoard #(
        .SETTLE_CYCLES (SETTLE_CYCLES)
    ) tubeBoardInst (
        .single_pulse_clk (single_pulse_clk),
        .rstN             (rstN),
        .phase            (phase),
        .pourReq          (pourReq),
        .board            (board),
        .setupDone        (setupDone),
        .pourBusy         (pourBusy),
        .solved           (solved)
    );

    ////////////////////////////////////////
    // Cursor and confirmation
    ////////////////////////////////////////
    playControl playControlInst (
        .single_pulse_clk (single_pulse_clk),
        .rstN             (rstN),
        .phase            (phase),
        .buttons          (buttons),
        .pourBusy         (pourBusy),
        .solved           (solved),
        .timeUp           (timeUp),
        .pourReq          (pourReq),
        .gameEnded        (gameEnded),
        .selectedMask     (selectedMask),
        .confirmedMask    (confirmedMask)
    );

    // Play clock
    gameTimer #(
        .TIME_LIMIT (TIME_LIMIT)
    ) gameTimerInst (
        .single_pulse_clk (single_pulse_clk),
        .rstN             (rstN),
        .phase            (phase),
        .timeUp           (timeUp),
        .timePercent      (timePercent)
    );

endmodule

//--- include/potionTbTasks.svh
// Idle outputs then layout load and settle count
task automatic setupSequence();
    if (board !== '0) reportMismatch("board", '0, board);
    if (setupDone !== 1'b0) reportMismatch("setupDone", 0, setupDone);
    if (gameEnded !== 1'b0) reportMismatch("gameEnded", 0, gameEnded);
    if (selectedMask !== 8'h01) reportMismatch("selectedMask", 8'h01, selectedMask);
    if (confirmedMask !== 8'h00) reportMismatch("confirmedMask", 0, confirmedMask);
    if (timePercent !== 7'd100) reportMismatch("timePercent", 100, timePercent);
    phase = potionPkg::SETUP;
    model = potionPkg::START_BOARD;
    for (int edges = 1; edges <= SETTLE_CYCLES + 2; edges++) begin
        tick(1);
        if (edges == 1 && board !== model) reportMismatch("board", model, board);
        if (setupDone !== (edges == SETTLE_CYCLES + 2)) begin
            reportMismatch("setupDone", edges == SETTLE_CYCLES + 2, setupDone);
        end
    end
    reportTest("setup");
endtask

task automatic cursorMoves();
    int moves [12] = '{BTN_LEFT, BTN_UP, BTN_RIGHT, BTN_RIGHT, BTN_RIGHT, BTN_RIGHT,
                       BTN_DOWN, BTN_RIGHT, BTN_LEFT, BTN_UP, BTN_DOWN, BTN_LEFT};
    int expCursor;
    expCursor = 0;
    phase = potionPkg::PLAY;
    foreach (moves[i]) begin
        press(buttonPulse(moves[i]));
        expCursor = stepCursor(expCursor, moves[i]);
        if (selectedMask !== 8'(1 << expCursor)) begin
            reportMismatch("selectedMask", 8'(1 << expCursor), selectedMask);
        end
    end
    press(buttonPulse(BTN_CENTRE));  // Confirm
    if (confirmedMask !== 8'(1 << expCursor)) begin
        reportMismatch("confirmedMask", 8'(1 << expCursor), confirmedMask);
    end
    press(buttonPulse(BTN_CENTRE));  // Same slot again unconfirms
    if (confirmedMask !== 8'h00) reportMismatch("confirmedMask", 0, confirmedMask);
    reportTest("cursor");
endtask

task automatic moveCursor(input int target);
    repeat (3) press(buttonPulse(BTN_LEFT));
    press(buttonPulse(BTN_UP));
    repeat (target % 4) press(buttonPulse(BTN_RIGHT));
    if (target >= 4) press(buttonPulse(BTN_DOWN));
endtask

// Source then destination with one press dropped mid pour
task automatic pourOnce(input int src, input int dst);
    moveCursor(src);
    press(buttonPulse(BTN_CENTRE));
    if (confirmedMask !== 8'(1 << src)) begin
        reportMismatch("confirmedMask", 8'(1 << src), confirmedMask);
    end
    moveCursor(dst);
    press(buttonPulse(BTN_CENTRE));
    waitUntil("pourBusy", 1'b1, 10);
    press(buttonPulse(dst < 4 ? BTN_DOWN : BTN_UP));
    waitUntil("pourBusy", 1'b0, 10);
    model = applyPour(model, src, dst);
    if (selectedMask !== 8'(1 << dst)) reportMismatch("selectedMask", 8'(1 << dst), selectedMask);
    if (confirmedMask !== 8'h00) reportMismatch("confirmedMask", 0, confirmedMask);
    if (board !== model) reportMismatch("board", model, board);
endtask

task automatic pourRules();
    int src;
    int dst;
    if (board !== model) reportMismatch("board", model, board);
    for (int i = 0; i < 10; i++) begin
        if (i == 0) begin
            src = 0;
            dst = 6;    // One unit onto the spare tube
        end else if (i == 1) begin
            src = 2;
            dst = 3;    // Full destination
        end else begin
            src = (nextRandom() >> 16) % 7;
            dst = (nextRandom() >> 16) % 7;
            if (dst == src) dst = (dst + 1) % 7;
        end
        pourOnce(src, dst);
    end
    reportTest("pour");
endtask

task automatic winByScript();
    int srcs [7] = '{0, 1, 1, 0, 0, 1, 1};
    int dsts [7] = '{6, 0, 6, 1, 6, 0, 6};
    phase = potionPkg::MENU;
    tick(2);
    phase = potionPkg::SETUP;
    waitUntil("setupDone", 1'b1, SETTLE_CYCLES + 5);
    phase = potionPkg::PLAY;
    model = potionPkg::START_BOARD;
    foreach (srcs[i]) begin
        pourOnce(srcs[i], dsts[i]);
        if (boardSolved(model)) begin
            waitUntil("gameEnded", 1'b1, 5);
        end else begin
            tick(3);  // Room for a false solved pulse
            if (gameEnded !== 1'b0) reportMismatch("gameEnded", 0, gameEnded);
        end
    end
    reportTest("win");
endtask

task automatic timerCountdown();
    int expPct;
    phase = potionPkg::MENU;
    tick(1);
    phase = potionPkg::PLAY;
    for (int k = 0; k <= TIME_LIMIT + 1; k++) begin
        // Reload on expiry wraps the remaining count
        expPct = (TIME_LIMIT - k % TIME_LIMIT) * 100 / TIME_LIMIT;
        if (timePercent !== 7'(expPct)) reportMismatch("timePercent", expPct, timePercent);
        if (gameEnded !== (k > TIME_LIMIT)) reportMismatch("gameEnded", k > TIME_LIMIT, gameEnded);
        tick(1);
    end
    reportTest("timer");
endtask

task automatic quitAndMenu();
    phase = potionPkg::MENU;
    tick(1);
    phase = potionPkg::PLAY;
    if (gameEnded !== 1'b0) reportMismatch("gameEnded", 0, gameEnded);
    moveCursor(potionPkg::QUIT_SLOT);
    press(buttonPulse(BTN_CENTRE));
    waitUntil("gameEnded", 1'b1, 5);
    press(buttonPulse(BTN_LEFT));
    press(buttonPulse(BTN_CENTRE));  // Hold slot 6 for the menu to clear
    if (confirmedMask !== 8'h40) reportMismatch("confirmedMask", 8'h40, confirmedMask);
    phase = potionPkg::MENU;
    tick(1);
    if (gameEnded !== 1'b0) reportMismatch("gameEnded", 0, gameEnded);
    if (selectedMask !== 8'h01) reportMismatch("selectedMask", 8'h01, selectedMask);
    if (confirmedMask !== 8'h00) reportMismatch("confirmedMask", 0, confirmedMask);
    reportTest("quit");
endtask

//--- verif/potionGameTb.sv
`timescale 1ns/100ps

module potionGameTb;

    localparam int TIME_LIMIT    = 400;
    localparam int SETTLE_CYCLES = 20;
    localparam int BTN_LEFT      = 0;
    localparam int BTN_RIGHT     = 1;
    localparam int BTN_UP        = 2;
    localparam int BTN_DOWN      = 3;
    localparam int BTN_CENTRE    = 4;

    logic               single_pulse_clk;
    logic               rstN;
    potionPkg::phaseT   phase;
    potionPkg::btnT     buttons;
    potionPkg::boardT   board;
    logic               setupDone;
    logic               gameEnded;
    logic [7:0]         selectedMask;
    logic [7:0]         confirmedMask;
    logic [6:0]         timePercent;

    potionPkg::boardT   model;  // Expected tube contents
    logic [31:0]        lcgState;
    int                 errCount;
    int                 errAtTestStart;
    int                 testsRun;
    int                 testsClean;

    potionGame #(
        .TIME_LIMIT    (25'(TIME_LIMIT)),
        .SETTLE_CYCLES (SETTLE_CYCLES)
    ) UUT (
        .single_pulse_clk (single_pulse_clk),
        .rstN             (rstN),
        .phase            (phase),
        .buttons          (buttons),
        .board            (board),
        .setupDone        (setupDone),
        .gameEnded        (gameEnded),
        .selectedMask     (selectedMask),
        .confirmedMask    (confirmedMask),
        .timePercent      (timePercent)
    );

    always #50 single_pulse_clk = ~single_pulse_clk;

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    function automatic int fillOf(input potionPkg::tubeT tube);
        int n;
        n = 0;
        for (int s = 0; s < potionPkg::TUBE_DEPTH; s++) begin
            if (tube[s] != potionPkg::EMPTY) n++;
        end
        return n;
    endfunction

    // Move units while the rule allows it
    function automatic potionPkg::boardT applyPour(input potionPkg::boardT b, input int src,
                                                   input int dst);
        potionPkg::boardT r;
        int sl;
        int dl;
        r = b;
        if (src == dst || src >= potionPkg::NUM_TUBES || dst >= potionPkg::NUM_TUBES) return r;
        for (int k = 0; k < potionPkg::TUBE_DEPTH; k++) begin
            sl = fillOf(r[src]);
            dl = fillOf(r[dst]);
            if (sl != 0 && dl < potionPkg::TUBE_DEPTH
                && (dl == 0 || r[dst][dl-1] == r[src][sl-1])) begin
                r[dst][dl]   = r[src][sl-1];
                r[src][sl-1] = potionPkg::EMPTY;
            end
        end
        return r;
    endfunction

    function automatic bit boardSolved(input potionPkg::boardT b);
        for (int t = 0; t < potionPkg::NUM_TUBES; t++) begin
            for (int s = 1; s < potionPkg::TUBE_DEPTH; s++) begin
                if (b[t][s] != b[t][0]) return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // Grid of two rows of four
    function automatic int stepCursor(input int cur, input int which);
        if (which == BTN_LEFT) return (cur % 4 == 0) ? cur : cur - 1;
        if (which == BTN_RIGHT) return (cur % 4 == 3) ? cur : cur + 1;
        if (which == BTN_UP) return (cur >= 4) ? cur - 4 : cur;
        if (which == BTN_DOWN) return (cur < 4) ? cur + 4 : cur;
        return cur;
    endfunction

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic potionPkg::btnT buttonPulse(input int which);
        return potionPkg::btnT'(5'b10000 >> which);  // Left is the top bit
    endfunction

    function automatic logic probe(input string name);
        if (name == "pourBusy") return UUT.pourBusy;
        if (name == "setupDone") return setupDone;
        return gameEnded;
    endfunction

    ////////////////////////////////////////
    // Stimulus and reporting helpers
    ////////////////////////////////////////
    task automatic tick(input int n);
        repeat (n) @(negedge single_pulse_clk);
    endtask

    task automatic press(input potionPkg::btnT b);
        buttons = b;
        tick(1);
        buttons = '0;
    endtask

    task automatic abortRun(input string why);
        $display("[%0t] %s", $time, why);
        $display("tests failed");
        $finish;
    endtask

    task automatic waitUntil(input string name, input logic level, input int limit);
        int n;
        n = 0;
        while (probe(name) !== level) begin
            if (n >= limit) abortRun($sformatf("timeout, %s never reached %0b", name, level));
            tick(1);
            n++;
        end
    endtask

    task automatic reportMismatch(input string name, input logic [127:0] expVal,
                                  input logic [127:0] actVal);
        $display("MISMATCH time %0t signal %s expected %0h actual %0h",
                 $time, name, expVal, actVal);
        errCount++;
    endtask

    task automatic reportTest(input string name);
        testsRun++;
        if (errCount == errAtTestStart) testsClean++;
        $display("[%0t] %s finished with %0d errors", $time, name, errCount - errAtTestStart);
        errAtTestStart = errCount;
    endtask

    `include "potionTbTasks.svh"

    initial begin
        single_pulse_clk = 1'b0;
        rstN             = 1'b0;
        phase            = potionPkg::MENU;
        buttons          = '0;
        lcgState         = 32'h8103f757;
        model            = '0;
        errCount         = 0;
        errAtTestStart   = 0;
        testsRun         = 0;
        testsClean       = 0;
        tick(5);  // Five reset edges
        rstN = 1'b1;

        setupSequence();
        cursorMoves();
        pourRules();
        winByScript();
        timerCountdown();
        quitAndMenu();

        $display("%0d tests run, %0d clean, %0d errors in total", testsRun, testsClean, errCount);
        if (errCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+include
hw/potionPkg.sv
hw/tubeBoard.sv
hw/playControl.sv
hw/gameTimer.sv
hw/potionGame.sv
verif/potionGameTb.sv

//--- Bender.yml
package:
  name: potion_game

sources:
  - hw/potionPkg.sv
  - hw/tubeBoard.sv
  - hw/playControl.sv
  - hw/gameTimer.sv
  - hw/potionGame.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/potionGameTb.sv
